// ==== cache2w.f ====
src/cache_pkg.sv
src/cache_way.sv
src/way_merge.sv
src/cache_cntrl_assoc.sv
src/main_mem.sv
src/cache_top.sv
testbench/cache_assertions.sv
testbench/cache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the cache testbench with verilator.
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -sv -f cache2w.f \
    --top-module cache_tb -Mdir obj_dir -o cache_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/cache_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$log"; then
    echo "simulation reported failing checks"
    exit 1
fi
exit 0

// ==== src/cache_cntrl_assoc.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_cntrl_assoc (
    input  wire logic                               clk,
    input  wire logic                               reset,
    input  wire cache_pkg::cpu_req_t                req,
    input  wire cache_pkg::merged_stat_t            merged,
    input  wire logic [cache_pkg::data_w-1:0]       mem_rdata,
    output cache_pkg::way_ctrl_t                    way_ctrl,
    output logic                                    lru_touch,
    output logic [$clog2(cache_pkg::num_ways)-1:0]  touch_way,
    output cache_pkg::mem_req_t                     mem_req,
    output logic [cache_pkg::data_w-1:0]            rdata,
    output logic                                    done,
    output logic                                    stall,
    output logic                                    cache_hit
);

    logic [3:0]                                     state;
    logic [3:0]                                     nxt_state;
    logic [3:0]                                     wb_off;
    logic [3:0]                                     rf_off;
    logic [$clog2(cache_pkg::words_per_line)-1:0]   fill_word;
    logic [$clog2(cache_pkg::num_ways)-1:0]         victim_q;
    logic [cache_pkg::data_w-1:0]                   fill_q;
    logic [cache_pkg::data_w-1:0]                   fill_data;
    logic [cache_pkg::data_w-1:0]                   read_word_q;

    assign wb_off = state - cache_pkg::st_wb_0;
    assign rf_off = state - cache_pkg::st_rf_0;

    // way writes trail the memory reads by two states.
    assign fill_word = rf_off[1:0] + 2'd2;

    // a write miss merges its own word into the refill.
    assign fill_data = (req.wr && (req.addr.fields.word == fill_word)) ? req.wdata : fill_q;

    always_comb begin
        nxt_state         = state;
        way_ctrl          = '0;
        way_ctrl.index    = req.addr.fields.index;
        way_ctrl.word     = req.addr.fields.word;
        way_ctrl.tag      = req.addr.fields.tag;
        way_ctrl.wdata    = req.wdata;
        mem_req           = '0;
        lru_touch         = 1'b0;
        touch_way         = merged.hit_way;
        rdata             = merged.rdata;
        done              = 1'b0;
        stall             = 1'b1;
        cache_hit         = 1'b0;

        case (state)
            cache_pkg::st_idle: begin
                stall = 1'b0;
                if (req.rd || req.wr) begin
                    nxt_state = cache_pkg::st_compare;
                end
            end
            cache_pkg::st_compare: begin
                way_ctrl.comp     = 1'b1;
                way_ctrl.write    = req.wr;
                way_ctrl.valid_in = 1'b1;
                way_ctrl.dirty_in = 1'b1;
                way_ctrl.way_sel  = '1;
                if (merged.hit) begin
                    done      = 1'b1;
                    cache_hit = 1'b1;
                    lru_touch = 1'b1;
                    nxt_state = cache_pkg::st_idle;
                end else if (merged.victim_valid && merged.victim_dirty) begin
                    nxt_state = cache_pkg::st_wb_0;
                end else begin
                    nxt_state = cache_pkg::st_rf_0;
                end
            end
            cache_pkg::st_wb_0, cache_pkg::st_wb_1,
            cache_pkg::st_wb_2, cache_pkg::st_wb_3: begin
                // victim line goes back one word per cycle.
                way_ctrl.word = wb_off[1:0];
                mem_req.write = 1'b1;
                mem_req.addr  = {merged.victim_tag, req.addr.fields.index, wb_off[1:0], 1'b0};
                mem_req.wdata = merged.rdata;
                nxt_state     = state + 4'd1;
            end
            cache_pkg::st_rf_0, cache_pkg::st_rf_1, cache_pkg::st_rf_2,
            cache_pkg::st_rf_3, cache_pkg::st_rf_4, cache_pkg::st_rf_5: begin
                if (state <= cache_pkg::st_rf_3) begin
                    mem_req.read = 1'b1;
                    mem_req.addr = {req.addr.fields.tag, req.addr.fields.index,
                                    rf_off[1:0], 1'b0};
                end
                if (state >= cache_pkg::st_rf_2) begin
                    way_ctrl.write              = 1'b1;
                    way_ctrl.valid_in           = 1'b1;
                    way_ctrl.dirty_in           = req.wr;
                    way_ctrl.way_sel[victim_q]  = 1'b1;
                    way_ctrl.word               = fill_word;
                    way_ctrl.wdata              = fill_data;
                end
                if (state == cache_pkg::st_rf_5) begin
                    done      = 1'b1;
                    lru_touch = 1'b1;
                    touch_way = victim_q;
                    rdata     = (req.addr.fields.word == 2'd3) ? fill_q : read_word_q;
                    nxt_state = cache_pkg::st_idle;
                end else begin
                    nxt_state = state + 4'd1;
                end
            end
            default: begin
                nxt_state = cache_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= cache_pkg::st_idle;
            victim_q <= '0;
        end else begin
            state <= nxt_state;
            if (state == cache_pkg::st_compare) begin
                victim_q <= merged.victim_way;
            end
        end
    end

    // memory word realigned to the way write slot.
    always_ff @(posedge clk) begin
        fill_q <= mem_rdata;
        if (state >= cache_pkg::st_rf_2 && fill_word == req.addr.fields.word) begin
            read_word_q <= fill_q;
        end
    end

endmodule

`default_nettype wire

// ==== src/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    localparam int num_ways       = 2;
    localparam int tag_w          = 5;
    localparam int idx_w          = 8;
    localparam int num_sets       = 256;
    localparam int words_per_line = 4;
    localparam int data_w         = 16;
    localparam int mem_words      = 32768;

    // memory starts as address plus this base.
    localparam logic [data_w-1:0] mem_init_base = 16'h5a00;

    // controller states.
    localparam logic [3:0] st_idle    = 4'd0;
    localparam logic [3:0] st_compare = 4'd1;
    localparam logic [3:0] st_wb_0    = 4'd2;
    localparam logic [3:0] st_wb_1    = 4'd3;
    localparam logic [3:0] st_wb_2    = 4'd4;
    localparam logic [3:0] st_wb_3    = 4'd5;
    localparam logic [3:0] st_rf_0    = 4'd6;
    localparam logic [3:0] st_rf_1    = 4'd7;
    localparam logic [3:0] st_rf_2    = 4'd8;
    localparam logic [3:0] st_rf_3    = 4'd9;
    localparam logic [3:0] st_rf_4    = 4'd10;
    localparam logic [3:0] st_rf_5    = 4'd11;

    typedef struct packed {
        logic [tag_w-1:0]                   tag;
        logic [idx_w-1:0]                   index;
        logic [$clog2(words_per_line)-1:0]  word;
        logic                               byte_bit;
    } cache_addr_fields_t;

    typedef union packed {
        logic [data_w-1:0]  flat;
        cache_addr_fields_t fields;
    } cache_addr_u;

    typedef struct packed {
        logic              rd;
        logic              wr;
        cache_addr_u       addr;
        logic [data_w-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                              comp;
        logic                              write;
        logic                              valid_in;
        logic                              dirty_in;
        logic [num_ways-1:0]               way_sel;
        logic [idx_w-1:0]                  index;
        logic [$clog2(words_per_line)-1:0] word;
        logic [tag_w-1:0]                  tag;
        logic [data_w-1:0]                 wdata;
    } way_ctrl_t;

    typedef struct packed {
        logic              hit;
        logic              valid;
        logic              dirty;
        logic [tag_w-1:0]  tag;
        logic [data_w-1:0] rdata;
    } way_stat_t;

    typedef struct packed {
        logic                        hit;
        logic [$clog2(num_ways)-1:0] hit_way;
        logic [$clog2(num_ways)-1:0] victim_way;
        logic                        victim_valid;
        logic                        victim_dirty;
        logic [tag_w-1:0]            victim_tag;
        logic [data_w-1:0]           rdata;
    } merged_stat_t;

    typedef struct packed {
        logic              read;
        logic              write;
        logic [data_w-1:0] addr;
        logic [data_w-1:0] wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== src/cache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_top (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire cache_pkg::cpu_req_t        req,
    output logic [cache_pkg::data_w-1:0]    rdata,
    output logic                            done,
    output logic                            stall,
    output logic                            cache_hit
);

    cache_pkg::way_ctrl_t                   way_ctrl;
    cache_pkg::way_stat_t                   way_stats [cache_pkg::num_ways];
    cache_pkg::merged_stat_t                merged;
    cache_pkg::mem_req_t                    mem_req;
    logic [cache_pkg::data_w-1:0]           mem_rdata;
    logic                                   lru_touch;
    logic [$clog2(cache_pkg::num_ways)-1:0] touch_way;

    cache_cntrl_assoc i_cntrl (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .merged    (merged),
        .mem_rdata (mem_rdata),
        .way_ctrl  (way_ctrl),
        .lru_touch (lru_touch),
        .touch_way (touch_way),
        .mem_req   (mem_req),
        .rdata     (rdata),
        .done      (done),
        .stall     (stall),
        .cache_hit (cache_hit)
    );

    // all ways see the same command.
    for (genvar w = 0; w < cache_pkg::num_ways; w++) begin : g_way
        cache_way #(
            .way_id (w)
        ) i_way (
            .clk   (clk),
            .reset (reset),
            .ctrl  (way_ctrl),
            .stat  (way_stats[w])
        );
    end

    way_merge i_merge (
        .clk       (clk),
        .reset     (reset),
        .stats     (way_stats),
        .index     (way_ctrl.index),
        .lru_touch (lru_touch),
        .touch_way (touch_way),
        .merged    (merged)
    );

    main_mem i_mem (
        .clk       (clk),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== src/cache_way.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_way #(
    parameter int way_id = 0
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire cache_pkg::way_ctrl_t ctrl,
    output cache_pkg::way_stat_t      stat
);

    logic [cache_pkg::tag_w-1:0]    tag_mem [cache_pkg::num_sets];
    logic [cache_pkg::data_w-1:0]   data_mem [cache_pkg::num_sets][cache_pkg::words_per_line];
    logic [cache_pkg::num_sets-1:0] valid_bits;
    logic [cache_pkg::num_sets-1:0] dirty_bits;
    logic                           way_we;

    // combinational lookup of the indexed set.
    always_comb begin
        stat.valid = valid_bits[ctrl.index];
        stat.dirty = dirty_bits[ctrl.index];
        stat.tag   = tag_mem[ctrl.index];
        stat.rdata = data_mem[ctrl.index][ctrl.word];
        stat.hit   = ctrl.comp & stat.valid & (stat.tag == ctrl.tag);
    end

    // a compare write lands only in the way that hits.
    assign way_we = ctrl.write & (ctrl.comp ? stat.hit : ctrl.way_sel[way_id]);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (way_we && ctrl.valid_in) begin
            valid_bits[ctrl.index] <= 1'b1;
            dirty_bits[ctrl.index] <= ctrl.dirty_in;
        end
    end

    always_ff @(posedge clk) begin
        if (way_we) begin
            data_mem[ctrl.index][ctrl.word] <= ctrl.wdata;
            if (ctrl.valid_in) begin
                tag_mem[ctrl.index] <= ctrl.tag;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/main_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module main_mem (
    input  wire logic                         clk,
    input  wire cache_pkg::mem_req_t          mem_req,
    output logic [cache_pkg::data_w-1:0]      mem_rdata
);

    logic [cache_pkg::data_w-1:0] mem [cache_pkg::mem_words];

    // known pattern so refilled lines can be predicted.
    initial begin
        for (int i = 0; i < cache_pkg::mem_words; i++) begin
            mem[i] = {i[14:0], 1'b0} + cache_pkg::mem_init_base;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_req.write) begin
            mem[mem_req.addr[15:1]] <= mem_req.wdata;
        end
    end

    // one cycle read latency.
    always_ff @(posedge clk) begin
        if (mem_req.read) begin
            mem_rdata <= mem[mem_req.addr[15:1]];
        end
    end

endmodule

`default_nettype wire

// ==== src/way_merge.sv ====
`timescale 1ns/10ps
`default_nettype none

module way_merge (
    input  wire logic                                   clk,
    input  wire logic                                   reset,
    input  wire cache_pkg::way_stat_t                   stats [cache_pkg::num_ways],
    input  wire logic [cache_pkg::idx_w-1:0]            index,
    input  wire logic                                   lru_touch,
    input  wire logic [$clog2(cache_pkg::num_ways)-1:0] touch_way,
    output cache_pkg::merged_stat_t                     merged
);

    // per set, the way to evict next.
    logic [cache_pkg::num_sets-1:0] lru_bits;

    always_comb begin
        logic found;
        merged = '0;
        found  = 1'b0;

        // invalid way first, lowest number wins.
        merged.victim_way = lru_bits[index];
        for (int i = 0; i < cache_pkg::num_ways; i++) begin
            if (!stats[i].valid && !found) begin
                merged.victim_way = i[$clog2(cache_pkg::num_ways)-1:0];
                found             = 1'b1;
            end
        end
        merged.victim_valid = stats[merged.victim_way].valid;
        merged.victim_dirty = stats[merged.victim_way].dirty;
        merged.victim_tag   = stats[merged.victim_way].tag;
        merged.rdata        = stats[merged.victim_way].rdata;

        // hit data overrides the victim word.
        for (int i = 0; i < cache_pkg::num_ways; i++) begin
            if (stats[i].hit) begin
                merged.hit     = 1'b1;
                merged.hit_way = i[$clog2(cache_pkg::num_ways)-1:0];
                merged.rdata   = stats[i].rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_bits <= '0;
        end else if (lru_touch) begin
            lru_bits[index] <= ~touch_way;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/cache_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_assertions (
    input wire logic                clk,
    input wire logic                reset,
    input wire logic                done,
    input wire logic                stall,
    input wire logic                cache_hit,
    input wire cache_pkg::mem_req_t mem_req
);

    a_hit_done: assert property (@(posedge clk) disable iff (reset) cache_hit |-> done)
        else $error("cache_hit without done");

    a_done_stall: assert property (@(posedge clk) disable iff (reset) done |-> stall)
        else $error("done while stall is low");

    // memory port is single command per cycle.
    a_mem_excl: assert property (@(posedge clk) disable iff (reset)
        !(mem_req.read && mem_req.write))
        else $error("memory read and write strobes together");

    a_done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done high for two cycles");

endmodule

bind cache_top cache_assertions i_cache_assertions (
    .clk       (clk),
    .reset     (reset),
    .done      (done),
    .stall     (stall),
    .cache_hit (cache_hit),
    .mem_req   (mem_req)
);

`default_nettype wire

// ==== testbench/cache_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_tb;

    localparam int num_entries = 24;
    localparam int num_fixed   = 14;
    localparam int max_wait    = 40;
    localparam logic [cache_pkg::data_w-1:0] pattern_base = 16'h5a00;

    typedef struct packed {
        logic                         wr;
        cache_pkg::cache_addr_u       addr;
        logic [cache_pkg::data_w-1:0] wdata;
        logic                         exp_hit;
        logic [cache_pkg::data_w-1:0] exp_data;
        logic [3:0]                   exp_lat;
    } stim_t;

    logic                         clk = 1'b0;
    logic                         reset;
    cache_pkg::cpu_req_t          req;
    logic [cache_pkg::data_w-1:0] rdata;
    logic                         done;
    logic                         stall;
    logic                         cache_hit;

    stim_t       stim [num_entries];
    logic [15:0] lfsr = 16'd22240;
    logic [7:0]  rand_idx [3] = '{8'h10, 8'h22, 8'h37};
    int          cur_entry;

    // reference model of memory contents and cache tags.
    logic [cache_pkg::data_w-1:0]   shadow [cache_pkg::mem_words];
    logic [cache_pkg::num_ways-1:0] m_valid [cache_pkg::num_sets];
    logic [cache_pkg::num_ways-1:0] m_dirty [cache_pkg::num_sets];
    logic [cache_pkg::tag_w-1:0]    m_tag [cache_pkg::num_sets][cache_pkg::num_ways];
    logic                           m_lru [cache_pkg::num_sets];

    int   data_errs  = 0;
    int   flag_errs  = 0;
    int   cycle_errs = 0;
    int   timeouts   = 0;
    logic timed_out  = 1'b0;

    cache_top i_cache_top (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .rdata     (rdata),
        .done      (done),
        .stall     (stall),
        .cache_hit (cache_hit)
    );

    always #20 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken.
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[14:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    task automatic set_entry(input int n, input logic wr, input logic [4:0] tag,
                             input logic [7:0] idx, input logic [1:0] word,
                             input logic [15:0] wdata);
        stim[n]                      = '0;
        stim[n].wr                   = wr;
        stim[n].addr.fields.tag      = tag;
        stim[n].addr.fields.index    = idx;
        stim[n].addr.fields.word     = word;
        stim[n].addr.fields.byte_bit = 1'b0;
        stim[n].wdata                = wdata;
    endtask

    task automatic predict(input int n);
        logic [cache_pkg::tag_w-1:0] tag;
        logic [cache_pkg::idx_w-1:0] idx;
        logic                        hit;
        logic                        way;
        tag = stim[n].addr.fields.tag;
        idx = stim[n].addr.fields.index;
        hit = 1'b0;
        way = 1'b0;
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
                hit = 1'b1;
                way = 1'(w);
            end
        end
        if (hit) begin
            stim[n].exp_lat = 4'd1;
        end else begin
            if (!m_valid[idx][0]) begin
                way = 1'b0;
            end else if (!m_valid[idx][1]) begin
                way = 1'b1;
            end else begin
                way = m_lru[idx];
            end
            stim[n].exp_lat = (m_valid[idx][way] && m_dirty[idx][way]) ? 4'd11 : 4'd7;
            m_valid[idx][way] = 1'b1;
            m_dirty[idx][way] = 1'b0;
            m_tag[idx][way]   = tag;
        end
        if (stim[n].wr) begin
            m_dirty[idx][way]              = 1'b1;
            shadow[stim[n].addr.flat[15:1]] = stim[n].wdata;
        end
        stim[n].exp_hit  = hit;
        stim[n].exp_data = shadow[stim[n].addr.flat[15:1]];
        m_lru[idx]       = ~way;
    endtask

    task automatic build_table();
        logic [15:0] r_sel;
        logic [15:0] r_tag;
        logic [15:0] r_word;
        logic [15:0] r_op;
        logic [15:0] r_data;
        for (int i = 0; i < cache_pkg::mem_words; i++) begin
            shadow[i] = 16'(2 * i) + pattern_base;
        end
        for (int s = 0; s < cache_pkg::num_sets; s++) begin
            m_valid[s] = '0;
            m_dirty[s] = '0;
            m_lru[s]   = 1'b0;
        end
        set_entry(0,  1'b0, 5'd1, 8'h10, 2'd1, 16'h0000);
        set_entry(1,  1'b0, 5'd1, 8'h10, 2'd1, 16'h0000);
        set_entry(2,  1'b1, 5'd1, 8'h10, 2'd2, 16'hbeef);
        set_entry(3,  1'b0, 5'd1, 8'h10, 2'd2, 16'h0000);
        set_entry(4,  1'b1, 5'd2, 8'h10, 2'd3, 16'h1234);
        set_entry(5,  1'b0, 5'd2, 8'h10, 2'd3, 16'h0000);
        set_entry(6,  1'b0, 5'd2, 8'h10, 2'd0, 16'h0000);
        set_entry(7,  1'b0, 5'd1, 8'h10, 2'd0, 16'h0000);
        set_entry(8,  1'b0, 5'd3, 8'h10, 2'd0, 16'h0000);
        set_entry(9,  1'b0, 5'd2, 8'h10, 2'd3, 16'h0000);
        set_entry(10, 1'b0, 5'd1, 8'h10, 2'd2, 16'h0000);
        set_entry(11, 1'b1, 5'd4, 8'h22, 2'd0, 16'ha5a5);
        set_entry(12, 1'b0, 5'd4, 8'h22, 2'd1, 16'h0000);
        set_entry(13, 1'b0, 5'd4, 8'h22, 2'd0, 16'h0000);
        // few tags over three sets so the ways conflict.
        for (int n = num_fixed; n < num_entries; n++) begin
            r_sel  = rand_bits(2);
            r_tag  = rand_bits(2);
            r_word = rand_bits(2);
            r_op   = rand_bits(1);
            r_data = rand_bits(16);
            set_entry(n, r_op[0], 5'(r_tag[1:0]) + 5'd1, rand_idx[r_sel[1:0] % 2'd3],
                      r_word[1:0], r_data);
        end
        for (int n = 0; n < num_entries; n++) begin
            predict(n);
        end
    endtask

    task automatic check_data(input string name, input logic [cache_pkg::data_w-1:0] got,
                              input logic [cache_pkg::data_w-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t entry %0d: %s got %h expected %h",
                     $time, cur_entry, name, got, exp);
            data_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t entry %0d: %s got %b expected %b",
                     $time, cur_entry, name, got, exp);
            flag_errs++;
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] %0t entry %0d: %s got %0d expected %0d",
                     $time, cur_entry, name, got, exp);
            cycle_errs++;
        end
    endtask

    // request is held from one rising edge until the edge after done.
    task automatic apply_entry(input int n);
        int   lat;
        logic seen;
        lat       = 0;
        seen      = 1'b0;
        cur_entry = n;
        req.rd    <= ~stim[n].wr;
        req.wr    <= stim[n].wr;
        req.addr  <= stim[n].addr;
        req.wdata <= stim[n].wdata;
        // controller still idle until the request is sampled.
        @(negedge clk);
        check_flag("stall", stall, 1'b0);
        @(posedge clk);
        while (!seen && lat < max_wait) begin
            @(negedge clk);
            lat++;
            seen = done;
            check_flag("stall", stall, 1'b1);
        end
        if (!seen) begin
            $display("timeout: entry %0d saw no done within %0d cycles", n, max_wait);
            timeouts++;
            timed_out = 1'b1;
        end else begin
            check_flag("cache_hit", cache_hit, stim[n].exp_hit);
            if (!stim[n].wr) begin
                check_data("rdata", rdata, stim[n].exp_data);
            end
            check_cycles("latency", lat, int'(stim[n].exp_lat));
        end
        @(posedge clk);
    endtask

    initial begin
        req   = '0;
        reset = 1'b1;
        build_table();
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        for (int n = 0; n < num_entries; n++) begin
            if (!timed_out) begin
                apply_entry(n);
            end
        end
        req <= '0;
        repeat (2) @(posedge clk);
        $display("errors: data %0d, flags %0d, cycles %0d, timeouts %0d",
                 data_errs, flag_errs, cycle_errs, timeouts);
        if (data_errs + flag_errs + cycle_errs + timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
